//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
FLIST     ?= flist.f

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(BUILD_DIR)

//--- flist.f
source/rv_core_pkg.sv
source/decode_if.sv
source/imm_gen.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu.sv
source/branch_unit.sv
source/core_sequencer.sv
source/rv_core.sv
testbench/rv_core_props.sv
testbench/tb_rv_core.sv

//--- source/alu.sv
// purely combinational; shift amount taken from the low 5 bits of b
module alu import rv_core_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:
                result = a + b;
            ALU_SUB:
                result = a - b;
            ALU_SLL:
                result = a << shamt;
            ALU_SRL:
                result = a >> shamt;
            ALU_SRA:
                result = word_t'($signed(a) >>> shamt);
            ALU_XOR:
                result = a ^ b;
            ALU_OR:
                result = a | b;
            ALU_AND:
                result = a & b;
            ALU_SLT:
                result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:
                result = {31'b0, a < b};
            ALU_PASS_B:
                result = b;                  // lui
            default:
                result = '0;
        endcase
    end

endmodule

//--- source/branch_unit.sv
// no alignment check on targets; jalr clears bit 0 only
module branch_unit import rv_core_pkg::*; (
    decode_if.consumer dec,
    input  word_t      pc,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    output word_t      next_pc,
    output word_t      link
);

    logic  taken;
    word_t jalr_target;

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = rs1_data == rs2_data;                    // beq
            3'b001:  taken = rs1_data != rs2_data;                    // bne
            3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);   // blt
            3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);  // bge
            3'b110:  taken = rs1_data < rs2_data;                     // bltu
            3'b111:  taken = rs1_data >= rs2_data;                    // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign jalr_target = rs1_data + dec.imm;
    assign link        = pc + PC_STEP;

    always_comb begin
        if (dec.is_jal || (dec.is_branch && taken)) begin
            next_pc = pc + dec.imm;
        end else if (dec.is_jalr) begin
            next_pc = {jalr_target[31:1], 1'b0};
        end else begin
            next_pc = link;
        end
    end

endmodule

//--- source/core_sequencer.sv
// fixed latency memories assumed (one cycle), no stall input; loads take 3 cycles, others 2
module core_sequencer import rv_core_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    decode_if.consumer dec,
    output logic       instr_read,
    output logic       data_read,
    output logic       data_write,
    output logic       commit,
    output logic       wb_enable
);

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        case (state)
            FETCH:   state_next = EXEC;
            EXEC:    state_next = dec.mem_read ? MEM : FETCH;
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    assign instr_read = state == FETCH;
    assign data_read  = state == EXEC && dec.mem_read;
    assign data_write = state == EXEC && dec.mem_write;   // memory writes at the closing edge
    assign commit     = (state == EXEC && !dec.mem_read) || state == MEM;
    assign wb_enable  = commit && dec.reg_write;

endmodule

//--- source/decode_if.sv
// decoded fields are combinational from the current instruction word and only valid after fetch
interface decode_if import rv_core_pkg::*; ();

    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    word_t       imm;
    logic [2:0]  funct3;        // branch condition select
    alu_op_t     alu_op;
    rd_src_t     rd_src;
    logic        reg_write;
    logic        alu_use_imm;
    logic        alu_use_pc;
    logic        mem_read;
    logic        mem_write;
    logic        is_branch;
    logic        is_jal;
    logic        is_jalr;

    modport decoder (output rs1, rs2, rd, imm, funct3, alu_op, rd_src, reg_write, alu_use_imm,
                     alu_use_pc, mem_read, mem_write, is_branch, is_jal, is_jalr);
    modport consumer (input rs1, rs2, rd, imm, funct3, alu_op, rd_src, reg_write, alu_use_imm,
                      alu_use_pc, mem_read, mem_write, is_branch, is_jal, is_jalr);

endinterface

//--- source/imm_gen.sv
// immediates for rv32i formats only; opcodes without an immediate give zero
module imm_gen import rv_core_pkg::*; (
    input  word_t instr,
    output word_t imm
);

    opcode_t    opcode;
    logic [2:0] funct3;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];

    always_comb begin
        case (opcode)
            OP_IMM: begin
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm = {27'b0, instr[24:20]};            // shamt only
                end else begin
                    imm = {{20{instr[31]}}, instr[31:20]};
                end
            end
            OP_LOAD, OP_JALR:
                imm = {{20{instr[31]}}, instr[31:20]};
            OP_STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OP_BRANCH:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {instr[31:12], 12'b0};
            OP_JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

//--- source/instr_decoder.sv
// memory funct3 is not checked, so every load/store acts on a full word; unknown opcodes are no-ops
module instr_decoder import rv_core_pkg::*; (
    input  word_t     instr,
    decode_if.decoder dec
);

    opcode_t opcode;
    word_t   imm;

    // sub only exists in the register form, sra in both
    function automatic alu_op_t funct_to_alu(input logic [2:0] funct3, input logic alt,
                                             input logic sub_ok);
        case (funct3)
            3'b000: return (alt && sub_ok) ? ALU_SUB : ALU_ADD;
            3'b001: return ALU_SLL;
            3'b010: return ALU_SLT;
            3'b011: return ALU_SLTU;
            3'b100: return ALU_XOR;
            3'b101: return alt ? ALU_SRA : ALU_SRL;
            3'b110: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_t'(instr[6:0]);

    imm_gen i_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    assign dec.rs1    = instr[19:15];
    assign dec.rs2    = instr[24:20];
    assign dec.rd     = instr[11:7];
    assign dec.funct3 = instr[14:12];
    assign dec.imm    = imm;

    always_comb begin
        dec.alu_op      = ALU_ADD;
        dec.rd_src      = RD_ALU;
        dec.reg_write   = 1'b0;
        dec.alu_use_imm = 1'b0;
        dec.alu_use_pc  = 1'b0;
        dec.mem_read    = 1'b0;
        dec.mem_write   = 1'b0;
        dec.is_branch   = 1'b0;
        dec.is_jal      = 1'b0;
        dec.is_jalr     = 1'b0;
        case (opcode)
            OP_REG: begin
                dec.alu_op    = funct_to_alu(instr[14:12], instr[30], 1'b1);
                dec.reg_write = 1'b1;
            end
            OP_IMM: begin
                dec.alu_op      = funct_to_alu(instr[14:12], instr[30], 1'b0);
                dec.reg_write   = 1'b1;
                dec.alu_use_imm = 1'b1;
            end
            OP_LOAD: begin
                dec.rd_src      = RD_MEM;
                dec.reg_write   = 1'b1;
                dec.alu_use_imm = 1'b1;   // address = rs1 + imm
                dec.mem_read    = 1'b1;
            end
            OP_STORE: begin
                dec.alu_use_imm = 1'b1;
                dec.mem_write   = 1'b1;
            end
            OP_BRANCH: dec.is_branch = 1'b1;
            OP_JAL: begin
                dec.rd_src    = RD_LINK;
                dec.reg_write = 1'b1;
                dec.is_jal    = 1'b1;
            end
            OP_JALR: begin
                dec.rd_src      = RD_LINK;
                dec.reg_write   = 1'b1;
                dec.alu_use_imm = 1'b1;
                dec.is_jalr     = 1'b1;
            end
            OP_LUI: begin
                dec.alu_op      = ALU_PASS_B;
                dec.reg_write   = 1'b1;
                dec.alu_use_imm = 1'b1;
            end
            OP_AUIPC: begin
                dec.reg_write   = 1'b1;
                dec.alu_use_imm = 1'b1;
                dec.alu_use_pc  = 1'b1;
            end
            default: ;                    // no-op that only advances the pc
        endcase
    end

endmodule

//--- source/reg_file.sv
// two combinational read ports, one write port on the rising edge; x0 always reads zero
module reg_file import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      write,
    input  reg_addr_t rd,
    input  word_t     rd_data
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write && rd != '0) begin   // x0 stays zero
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

//--- source/rv_core.sv
// multi-cycle rv32i subset core; memories must answer one cycle after a strobe, no back-pressure
module rv_core import rv_core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    output logic  instr_read,
    output word_t instr_addr,
    input  word_t instr_out,
    output logic  data_read,
    output logic  data_write,
    output word_t data_addr,
    output word_t data_in,
    input  word_t data_out
);

    decode_if dec ();

    word_t pc;
    word_t next_pc;
    word_t link;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    word_t wb_data;
    logic  commit;
    logic  wb_enable;

    instr_decoder i_instr_decoder (
        .instr (instr_out),
        .dec   (dec)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .write    (wb_enable),
        .rd       (dec.rd),
        .rd_data  (wb_data)
    );

    assign alu_a = dec.alu_use_pc ? pc : rs1_data;        // auipc
    assign alu_b = dec.alu_use_imm ? dec.imm : rs2_data;

    alu i_alu (
        .op     (dec.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    branch_unit i_branch_unit (
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .next_pc  (next_pc),
        .link     (link)
    );

    core_sequencer i_core_sequencer (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec),
        .instr_read (instr_read),
        .data_read  (data_read),
        .data_write (data_write),
        .commit     (commit),
        .wb_enable  (wb_enable)
    );

    always_comb begin
        case (dec.rd_src)
            RD_MEM:  wb_data = data_out;
            RD_LINK: wb_data = link;
            default: wb_data = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (commit) begin
            pc <= next_pc;
        end
    end

    assign instr_addr = pc;
    assign data_addr  = alu_result;   // rs1 + imm for lw/sw
    assign data_in    = rs2_data;

endmodule

//--- source/rv_core_pkg.sv
// rv32i subset only (no byte/half memory access, no csr or traps), little-endian word addressing
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t PC_STEP  = 32'd4;   // one instruction
    localparam word_t RESET_PC = 32'd0;

    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B   // forwards operand b
    } alu_op_t;

    typedef enum logic [1:0] {
        RD_ALU,
        RD_MEM,
        RD_LINK      // pc + 4
    } rd_src_t;

endpackage

//--- testbench/rv_core_props.sv
// strobe protocol checks on the rising edge; reset cycles are not checked
module rv_core_props (
    input logic clk,
    input logic rst,
    input logic instr_read,
    input logic data_read,
    input logic data_write
);

    fetch_one_cycle: assert property (@(posedge clk) disable iff (rst)
        instr_read |=> !instr_read)
        else $error("instr_read stayed high for more than one cycle");

    no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(data_read && data_write))
        else $error("data_read and data_write high together");

    store_then_fetch: assert property (@(posedge clk) disable iff (rst)
        data_write |=> instr_read)
        else $error("no fetch in the cycle after a store");

    // load goes through MEM first
    load_then_fetch: assert property (@(posedge clk) disable iff (rst)
        data_read |-> ##2 instr_read)
        else $error("no fetch two cycles after a load");

endmodule

bind rv_core rv_core_props i_rv_core_props (
    .clk        (clk),
    .rst        (rst),
    .instr_read (instr_read),
    .data_read  (data_read),
    .data_write (data_write)
);

//--- testbench/tb_rv_core.sv
// directed tests; memories are modeled here with one-cycle latency, stores land from 0x200 upward
module tb_rv_core import rv_core_pkg::*; ();

    localparam int    IMEM_WORDS     = 128;
    localparam int    DMEM_WORDS     = 256;
    localparam int    TIMEOUT_CYCLES = 2 * 6 * 32 * 3;   // tests x instrs x cycles x 2
    localparam word_t VAL_A          = 32'h1234_5678;
    localparam word_t VAL_N          = 32'hFFFF_FC18;    // -1000

    logic  clk;
    logic  rst;
    logic  instr_read;
    word_t instr_addr;
    word_t instr_out;
    logic  data_read;
    logic  data_write;
    word_t data_addr;
    word_t data_in;
    word_t data_out;
    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    word_t exp_addr [$];
    word_t exp_data [$];
    string test_name;
    int    prog_len;
    word_t store_off;
    int    cycle_count;
    int    seed;

    rv_core i_rv_core (.clk(clk), .rst(rst), .instr_read(instr_read), .instr_addr(instr_addr),
                       .instr_out(instr_out), .data_read(data_read), .data_write(data_write),
                       .data_addr(data_addr), .data_in(data_in), .data_out(data_out));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles in %s", cycle_count, test_name));
        end
    end

    // memory models answer on the falling edge
    always @(negedge clk) begin
        if (data_write) begin
            check_strobe(test_name, exp_addr.size() != 0, 1'b1);
            check_word({test_name, " store address"}, exp_addr.pop_front(), data_addr);
            check_word({test_name, " store data"}, exp_data.pop_front(), data_in);
            dmem[data_addr[9:2]] = data_in;
        end
        if (data_read) data_out = dmem[data_addr[9:2]];
        if (instr_read) instr_out = imem[instr_addr[8:2]];
    end

    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction
    function automatic word_t i_type(input word_t imm, input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd, input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction
    function automatic word_t s_type(input word_t imm, input reg_addr_t rs2, input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction
    function automatic word_t b_type(input word_t imm, input reg_addr_t rs2, input reg_addr_t rs1,
                                     input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction
    function automatic word_t u_type(input word_t imm, input reg_addr_t rd, input logic [6:0] op);
        return {imm[31:12], rd, op};
    endfunction
    function automatic word_t j_type(input word_t imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction
    function automatic word_t here();
        return word_t'(prog_len * 4);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s expected %08h actual %08h", name, expected,
                                     actual));
        end
    endtask

    task automatic check_strobe(input string name, input logic expected, input logic seen);
        if (seen && !expected) report_failure({name, ": the core made a store nobody expected"});
        else if (!seen && expected) report_failure({name, ": an expected store never happened"});
    endtask

    task automatic begin_program(input string name);
        test_name = name;
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = i_type(i, 0, 3'b000, 0, OP_IMM);
        prog_len  = 0;
        store_off = 32'h200;
    endtask

    task automatic emit(input word_t instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic store_check(input reg_addr_t rs, input word_t expected);
        emit(s_type(store_off, rs, 0));
        expect_store(store_off, expected);
        store_off = store_off + 32'd4;
    endtask

    task automatic load_const(input reg_addr_t rd, input word_t value);
        emit(u_type(value + 32'h800, rd, OP_LUI));   // addi sign-extends the low part
        emit(i_type(value, rd, 3'b000, rd, OP_IMM));
    endtask

    task automatic alu_r(input logic [2:0] f3, input logic alt, input reg_addr_t rs1,
                         input reg_addr_t rs2, input word_t expected);
        emit(r_type(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, 5));
        store_check(5, expected);
    endtask

    task automatic alu_i(input logic [2:0] f3, input word_t imm, input reg_addr_t rs1,
                         input word_t expected);
        emit(i_type(imm, rs1, f3, 5, OP_IMM));
        store_check(5, expected);
    endtask

    task automatic branch_case(input logic [2:0] f3, input reg_addr_t rs1, input reg_addr_t rs2,
                               input logic taken);
        emit(b_type(32'd12, rs2, rs1, f3));
        emit(i_type(32'd1, 0, 3'b000, 5, OP_IMM));   // not-taken marker
        emit(j_type(32'd8, 0));
        emit(i_type(32'd2, 0, 3'b000, 5, OP_IMM));   // taken marker
        store_check(5, taken ? 32'd2 : 32'd1);
    endtask

    task automatic reset_core();
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic wait_for_fetch(input word_t addr);
        @(negedge clk);
        while (!(instr_read && instr_addr == addr)) @(negedge clk);
    endtask

    task automatic run_program();
        word_t halt;
        halt = here();
        emit(j_type(32'd0, 0));                      // jump-to-self ends the program
        reset_core();
        wait_for_fetch(halt);
        check_strobe(test_name, exp_addr.size() != 0, 1'b0);
    endtask

    task automatic alu_ops();
        begin_program("alu_ops");
        load_const(1, VAL_A);
        load_const(3, VAL_N);
        emit(i_type(32'd5, 0, 3'b000, 4, OP_IMM));
        alu_r(3'b000, 1'b0, 1, 3, VAL_A + VAL_N);
        alu_r(3'b000, 1'b1, 1, 3, VAL_A - VAL_N);
        alu_r(3'b001, 1'b0, 1, 4, VAL_A << 5);
        alu_r(3'b101, 1'b0, 3, 4, VAL_N >> 5);
        alu_r(3'b101, 1'b1, 3, 4, 32'hFFFF_FFE0);   // -1000 >> 5 rounds down to -32
        alu_r(3'b100, 1'b0, 1, 3, VAL_A ^ VAL_N);
        alu_r(3'b110, 1'b0, 1, 3, VAL_A | VAL_N);
        alu_r(3'b111, 1'b0, 1, 3, VAL_A & VAL_N);
        alu_r(3'b010, 1'b0, 3, 1, 1);                // -1000 < positive when signed
        alu_r(3'b011, 1'b0, 3, 1, 0);
        alu_i(3'b000, -7, 1, VAL_A - 7);
        alu_i(3'b100, 32'h5A5, 3, VAL_N ^ 32'h5A5);
        alu_i(3'b110, 32'h0F0, 1, VAL_A | 32'h0F0);
        alu_i(3'b111, -16, 1, VAL_A & 32'hFFFF_FFF0);
        alu_i(3'b010, 3, 3, 1);
        alu_i(3'b011, 3, 3, 0);
        alu_i(3'b011, -1, 1, 1);
        alu_i(3'b001, 7, 1, VAL_A << 7);
        alu_i(3'b101, 9, 3, VAL_N >> 9);
        alu_i(3'b101, 32'h409, 3, 32'hFFFF_FFFE);    // -1000 >> 9 rounds down to -2
        run_program();
    endtask

    task automatic upper_immediates();
        begin_program("upper_immediates");
        emit(u_type(32'hABCD_E000, 6, OP_LUI));
        store_check(6, 32'hABCD_E000);
        store_check(7, here() + 32'h1234_5000);      // auipc result precomputed from its address
        imem[prog_len - 1] = u_type(32'h1234_5000, 7, OP_AUIPC);
        emit(s_type(store_off - 32'd4, 7, 0));
        store_check(8, here() + 32'hFFFF_F000);
        imem[prog_len - 1] = u_type(32'hFFFF_F000, 8, OP_AUIPC);
        emit(s_type(store_off - 32'd4, 8, 0));
        run_program();
    endtask

    task automatic load_store();
        word_t seed_a;
        word_t seed_b;
        seed_a = dmem[16];
        seed_b = dmem[18];
        begin_program("load_store");
        load_const(1, VAL_A);
        load_const(2, 32'h0BAD_F00D);
        emit(s_type(32'h300, 1, 0));
        expect_store(32'h300, VAL_A);
        emit(s_type(32'h304, 2, 0));
        expect_store(32'h304, 32'h0BAD_F00D);
        emit(i_type(32'h300, 0, 3'b010, 3, OP_LOAD));
        emit(i_type(32'h304, 0, 3'b010, 4, OP_LOAD));
        emit(r_type(7'b0000000, 4, 3, 3'b000, 5));
        store_check(5, VAL_A + 32'h0BAD_F00D);
        emit(i_type(32'h040, 0, 3'b010, 6, OP_LOAD));
        emit(i_type(32'h100, 0, 3'b000, 9, OP_IMM));
        emit(i_type(-32'sd184, 9, 3'b010, 7, OP_LOAD));   // 0x100 - 0xb8 = 0x48
        emit(r_type(7'b0000000, 7, 6, 3'b000, 8));
        store_check(6, seed_a);
        store_check(8, seed_a + seed_b);
        run_program();
    endtask

    task automatic branches();
        begin_program("branches");
        emit(i_type(-1, 0, 3'b000, 1, OP_IMM));
        emit(i_type(32'd1, 0, 3'b000, 2, OP_IMM));
        branch_case(3'b000, 1, 1, 1'b1);
        branch_case(3'b000, 1, 2, 1'b0);
        branch_case(3'b001, 1, 2, 1'b1);
        branch_case(3'b001, 1, 1, 1'b0);
        branch_case(3'b100, 1, 2, 1'b1);
        branch_case(3'b100, 2, 1, 1'b0);
        branch_case(3'b101, 2, 1, 1'b1);
        branch_case(3'b101, 1, 2, 1'b0);
        branch_case(3'b110, 2, 1, 1'b1);
        branch_case(3'b110, 1, 2, 1'b0);
        branch_case(3'b111, 1, 2, 1'b1);
        branch_case(3'b111, 2, 1, 1'b0);
        run_program();
    endtask

    task automatic jumps();
        word_t base;
        begin_program("jumps");
        base = here();
        emit(j_type(32'd8, 1));
        emit(s_type(32'h3F0, 0, 0));                 // skipped
        store_check(1, base + 32'd4);
        base = here();
        emit(i_type(base + 32'd12, 0, 3'b000, 2, OP_IMM));
        emit(i_type(32'd1, 2, 3'b000, 3, OP_JALR));  // odd target has bit 0 dropped
        emit(s_type(32'h3F4, 0, 0));                 // skipped
        store_check(3, base + 32'd8);
        run_program();
    endtask

    task automatic x0_and_reset();
        begin_program("x0_and_reset");
        emit(i_type(32'd55, 0, 3'b000, 1, OP_IMM));
        emit(i_type(32'd123, 0, 3'b000, 0, OP_IMM));
        emit(u_type(32'hFFFF_F000, 0, OP_LUI));
        emit(r_type(7'b0000000, 1, 1, 3'b000, 0));
        store_check(0, 32'd0);
        store_check(1, 32'd55);
        run_program();
        begin_program("second_reset");
        emit(j_type(32'd0, 0));
        reset_core();
        check_word("second_reset fetch strobe", 32'd1, {31'b0, instr_read});
        check_word("second_reset fetch address", 32'd0, instr_addr);
        wait_for_fetch(32'd0);
    endtask

    initial begin
        rst         = 1'b1;
        instr_out   = '0;
        data_out    = '0;
        cycle_count = 0;
        seed        = 82;
        test_name   = "startup";
        for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = $random(seed);
        alu_ops();
        upper_immediates();
        load_store();
        branches();
        jumps();
        x0_and_reset();
        $display("TEST OK");
        $finish;
    end

endmodule
